// ==== dv/boot_image.hex ====
// One 32-bit instruction word per line in hex, ROM word 0 first.
00000297
02028293
30529073
00000093
00000113
00000193
00000213
00000293
00000313
00000393
00000413
00000493
00000513
00000593
00000613
00000693
00000713
00000793
00000813
00000893
00000913
00000993
00000a13
00000a93
00000b13
00000b93
00000c13
00000c93
00000d13
00000d93
00000e13
00000e93
00000f13
00000f93
10000537
00050513
000015b7
80058593
00b50633
00062683
00d62023
00460613
fec5cae3
00100713
00e52023
20000637
00060613
00062703
00177713
fe070ce3
00462783
00f52223
00150513
fe5ff06f
30200073
10500073
0ff0000f
0000100f
00008067
00000013
34102573
34202673
00000073
0000006f

// ==== sources.f ====
logic/mem_pkg.sv
logic/boot_pkg.sv
logic/word_rom.sv
logic/beat_counter.sv
logic/line_assembler.sv
logic/fill_ctrl.sv
logic/instr_fill.sv
dv/instr_fill_assert.sv
dv/instr_fill_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module instr_fill_tb -f sources.f -o instr_fill_sim

output=$(./obj_dir/instr_fill_sim || true)
echo "$output"

if echo "$output" | grep -qx "NO ERRORS"; then
	exit 0
fi
echo "Simulation did not pass."
exit 1

// ==== dv/instr_fill_tb.sv ====
`timescale 1ns/1ps

module instr_fill_tb;

	import mem_pkg::*;

	localparam int          timeout_cycles = 1500;
	localparam int          base_word      = 32'h20 / 4; // ROM word 0 sits at slot 8 of line 0.
	localparam int          rom_words      = 64;
	localparam int          line_count     = 6;
	localparam logic [31:0] seed           = 32'hc55d;

	logic       clk = 1'b0;
	logic       rstn;
	logic       stall;
	logic       line_req;
	logic       line_valid;
	line_t      line_data;
	line_addr_t line_addr;

	logic [31:0] model_rom [rom_words];
	int          cycle_count  = 0;
	int          error_count  = 0;
	int          check_count  = 0;
	int          test_count   = 0;
	int          tests_passed = 0;
	int          next_line    = 0;
	int          strobe_count = 0;

	instr_fill dut0 (
		.clk        (clk),
		.rstn       (rstn),
		.stall      (stall),
		.line_req   (line_req),
		.line_valid (line_valid),
		.line_data  (line_data),
		.line_addr  (line_addr)
	);

	bind instr_fill instr_fill_assert u_fill_assert (
		.clk        (clk),
		.rstn       (rstn),
		.stall      (stall),
		.line_valid (line_valid),
		.line_data  (line_data),
		.line_addr  (line_addr)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles.", timeout_cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// Every strobe is counted, whichever test is running.
	always @(negedge clk) begin
		if (rstn && line_valid) begin
			strobe_count++;
		end
	end

	// ----------------------------------------------------------------------
	// Checking and reference model
	// ----------------------------------------------------------------------
	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
				expected);
		end
	endtask

	function automatic logic [31:0] expected_word(input int line, input int slot);
		int idx;
		idx = line * words_per_line + slot - base_word;
		if (idx < 0 || idx >= rom_words) begin
			return '0; // Outside the image.
		end
		return model_rom[idx];
	endfunction

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			tests_passed++;
			$display("%s: passed", name);
		end
		else begin
			$display("%s: failed with %0d mismatches", name, error_count - errors_before);
		end
	endtask

	// Runs one line from its start edge to line_valid and checks it.
	task automatic fill_line(input logic use_stall, input logic request);
		int cycles;
		int stalls;
		cycles = 0;
		stalls = 0;
		check_value(32'(line_addr), next_line, "line address before start");
		line_req = request;
		do begin
			@(posedge clk);
			#1;
			cycles++;
			line_req = 1'b0;
			stall = use_stall && (cycles >= 2) && (cycles < 24) && (($urandom % 4) == 0);
			stalls += int'(stall);
		end while (!line_valid);
		check_value(cycles, 32 + stalls, "cycles from start to line_valid");
		check_value(32'(line_addr), next_line + 1, "line address after line");
		for (int s = 0; s < words_per_line; s++) begin
			check_value(line_data[s*word_w +: word_w], expected_word(next_line, s),
				$sformatf("line %0d slot %0d", next_line, s));
		end
		next_line++;
	endtask

	// ----------------------------------------------------------------------
	// Directed tests
	// ----------------------------------------------------------------------
	task automatic boot_line();
		int errs;
		errs = error_count;
		repeat (16) @(posedge clk);
		#1;
		check_value(32'(line_valid), 0, "line_valid in reset");
		check_value(32'(line_data != '0), 0, "line_data not zero in reset");
		rstn = 1'b1;
		fill_line(1'b0, 1'b0); // The boot line needs no request.
		report_test("boot_line", errs);
	endtask

	task automatic requested_lines();
		int errs;
		errs = error_count;
		repeat (2) fill_line(1'b0, 1'b1);
		report_test("requested_lines", errs);
	endtask

	task automatic stalled_line();
		int errs;
		errs = error_count;
		fill_line(1'b1, 1'b1);
		report_test("stalled_line", errs);
	endtask

	task automatic end_of_rom();
		int errs;
		errs = error_count;
		repeat (2) fill_line(1'b0, 1'b1);
		report_test("end_of_rom", errs);
	endtask

	task automatic idle_hold();
		int         errs;
		line_t      held_data;
		line_addr_t held_addr;
		errs = error_count;
		held_data = line_data;
		held_addr = line_addr;
		repeat (100) begin
			@(posedge clk);
			#1;
			check_value(32'(line_valid), 0, "line_valid while idle");
			check_value(32'(line_data != held_data), 0, "line_data changed while idle");
			check_value(32'(line_addr), 32'(held_addr), "line_addr while idle");
		end
		report_test("idle_hold", errs);
	endtask

	initial begin
		rstn     = 1'b0;
		stall    = 1'b0;
		line_req = 1'b0;
		void'($urandom(seed));
		$readmemh("dv/boot_image.hex", model_rom);
		boot_line();
		requested_lines();
		stalled_line(); // Line 3 still holds ROM words.
		end_of_rom();
		idle_hold();
		check_value(strobe_count, line_count, "number of line_valid strobes");
		$display("Summary: %0d of %0d tests passed, %0d checks, %0d mismatches",
			tests_passed, test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end
		else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== dv/instr_fill_assert.sv ====
`timescale 1ns/1ps

module instr_fill_assert (
	input logic                clk,
	input logic                rstn,
	input logic                stall,
	input logic                line_valid,
	input mem_pkg::line_t      line_data,
	input mem_pkg::line_addr_t line_addr
);

	// ----------------------------------------------------------------------
	// Strobe and address rules
	// ----------------------------------------------------------------------
	property single_cycle_strobe;
		@(posedge clk) disable iff (!rstn)
			line_valid |-> !$past(line_valid);
	endproperty

	// A stalled edge neither captures a word nor advances the address.
	property stall_freezes_line;
		@(posedge clk) disable iff (!rstn)
			stall |=> ($stable(line_addr) && $stable(line_data));
	endproperty

	// A stall right after the last capture holds the strobe back by a cycle.
	property addr_moves_with_strobe;
		@(posedge clk) disable iff (!rstn)
			(line_addr != $past(line_addr)) |-> (line_valid || stall);
	endproperty

	a_single_cycle_strobe: assert property (single_cycle_strobe)
		else $error("line_valid was high for two cycles in a row.");
	a_stall_freezes_line: assert property (stall_freezes_line)
		else $error("line_data or line_addr changed across a stalled cycle.");
	a_addr_moves_with_strobe: assert property (addr_moves_with_strobe)
		else $error("line_addr changed without a line_valid strobe.");

endmodule

// ==== logic/instr_fill.sv ====
`timescale 1ns/1ps

module instr_fill (
	input  logic                clk,
	input  logic                rstn,
	input  logic                stall,
	input  logic                line_req,
	output logic                line_valid,
	output mem_pkg::line_t      line_data,
	output mem_pkg::line_addr_t line_addr
);

	import mem_pkg::*;
	import boot_pkg::*;

	logic      capture;
	logic      last_beat;
	logic      in_range;
	beat_t     beat;
	rom_addr_t rom_addr;
	word_t     rom_word;

	// ----------------------------------------------------------------------
	// Sequencing
	// ----------------------------------------------------------------------
	fill_ctrl u_fill_ctrl (
		.clk        (clk),
		.rstn       (rstn),
		.stall      (stall),
		.line_req   (line_req),
		.last_beat  (last_beat),
		.capture    (capture),
		.line_valid (line_valid)
	);

	beat_counter u_beat_counter (
		.clk       (clk),
		.rstn      (rstn),
		.capture   (capture),
		.beat      (beat),
		.last_beat (last_beat),
		.line_addr (line_addr),
		.rom_addr  (rom_addr),
		.in_range  (in_range)
	);

	// ----------------------------------------------------------------------
	// Data path
	// ----------------------------------------------------------------------
	word_rom u_word_rom (
		.clk  (clk),
		.addr (rom_addr),
		.data (rom_word)
	);

	line_assembler u_line_assembler (
		.clk       (clk),
		.rstn      (rstn),
		.capture   (capture),
		.beat      (beat),
		.in_range  (in_range),
		.rom_word  (rom_word),
		.line_data (line_data)
	);

endmodule

// ==== logic/fill_ctrl.sv ====
`timescale 1ns/1ps

module fill_ctrl (
	input  logic clk,
	input  logic rstn,
	input  logic stall,
	input  logic line_req,
	input  logic last_beat,
	output logic capture,
	output logic line_valid
);

	import boot_pkg::*;

	fill_state_t state_q;
	fill_state_t state_d;
	logic        boot_q;   // Set until the boot line has been started.
	logic        valid_q;  // Line completed at the last active edge.
	logic        start;

	assign start = boot_q | line_req;

	// ----------------------------------------------------------------------
	// Next state
	// ----------------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		unique case (state_q)
			st_wait: begin
				// The ROM keeps reading beat 0 while idle, so the start edge
				// also serves as the read for the first word.
				if (start) begin
					state_d = st_capture;
				end
			end
			st_read: begin
				state_d = st_capture;
			end
			st_capture: begin
				if (last_beat) begin
					state_d = st_wait;
				end
				else begin
					state_d = st_read;
				end
			end
			default: begin
				state_d = st_wait;
			end
		endcase
	end

	// ----------------------------------------------------------------------
	// State registers
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= st_wait;
			boot_q  <= 1'b1;
			valid_q <= 1'b0;
		end
		else if (!stall) begin
			state_q <= state_d;
			valid_q <= capture & last_beat;
			if ((state_q == st_wait) && start) begin
				boot_q <= 1'b0;
			end
		end
	end

	assign capture    = (state_q == st_capture) & ~stall;
	assign line_valid = valid_q & ~stall; // Held strobe resumes after the stall.

endmodule

// ==== logic/line_assembler.sv ====
`timescale 1ns/1ps

module line_assembler (
	input  logic           clk,
	input  logic           rstn,
	input  logic           capture,
	input  mem_pkg::beat_t beat,
	input  logic           in_range,
	input  mem_pkg::word_t rom_word,
	output mem_pkg::line_t line_data
);

	import mem_pkg::*;

	word_t slot_word;
	line_t line_q;

	// Holes in the address map read as zero.
	assign slot_word = in_range ? rom_word : '0;

	// ----------------------------------------------------------------------
	// Line register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rstn) begin
			line_q <= '0;
		end
		else if (capture) begin
			for (int i = 0; i < words_per_line; i++) begin
				if (beat == beat_t'(i)) begin
					line_q[i*word_w +: word_w] <= slot_word; // One slot per capture.
				end
			end
		end
	end

	// Slots of the previous line stay visible until they are overwritten.
	assign line_data = line_q;

endmodule

// ==== logic/beat_counter.sv ====
`timescale 1ns/1ps

module beat_counter (
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  capture,
	output mem_pkg::beat_t        beat,
	output logic                  last_beat,
	output mem_pkg::line_addr_t   line_addr,
	output boot_pkg::rom_addr_t   rom_addr,
	output logic                  in_range
);

	import mem_pkg::*;
	import boot_pkg::*;

	beat_t      beat_q;
	line_addr_t line_addr_q;
	word_addr_t word_pos;   // Word position of the current slot.
	word_addr_t base_pos;   // Word position of the first ROM word.
	word_addr_t word_idx;   // Offset into the ROM, may wrap below zero.

	// ----------------------------------------------------------------------
	// Beat and line address
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rstn) begin
			beat_q      <= '0;
			line_addr_q <= boot_base[31:line_off_w];
		end
		else if (capture) begin
			beat_q <= beat_q + 1'b1; // Wraps from 15 back to 0.
			if (last_beat) begin
				line_addr_q <= line_addr_q + 1'b1;
			end
		end
	end

	assign last_beat = (beat_q == beat_t'(words_per_line - 1));
	assign beat      = beat_q;
	assign line_addr = line_addr_q;

	// ----------------------------------------------------------------------
	// ROM address and range check
	// ----------------------------------------------------------------------
	assign word_pos = {line_addr_q, beat_q};
	assign base_pos = boot_base[31:word_off_w];
	assign word_idx = word_pos - base_pos;

	// Below the base the subtraction wraps, so the lower bound is checked
	// on the unsubtracted position.
	assign in_range = (word_pos >= base_pos) && (word_idx < word_addr_t'(rom_depth));
	assign rom_addr = word_idx[rom_addr_w-1:0];

endmodule

// ==== logic/word_rom.sv ====
`timescale 1ns/1ps

module word_rom (
	input  logic                clk,
	input  boot_pkg::rom_addr_t addr,
	output mem_pkg::word_t      data
);

	import mem_pkg::*;
	import boot_pkg::*;

	word_t rom_mem [rom_depth];

	// Image is fixed at build time; there is no write port.
	initial begin
		$readmemh(boot_image, rom_mem);
	end

	// Free running read, so the word for the current address is always
	// one cycle behind it.
	always_ff @(posedge clk) begin
		data <= rom_mem[addr];
	end

endmodule

// ==== logic/boot_pkg.sv ====
package boot_pkg;

	// ----------------------------------------------------------------------
	// Boot ROM image
	// ----------------------------------------------------------------------
	localparam int rom_depth  = 64;
	localparam int rom_addr_w = $clog2(rom_depth);

	typedef logic [rom_addr_w-1:0] rom_addr_t;

	localparam logic [31:0] boot_base  = 32'h0000_0020; // Word 8 of line 0.
	localparam string       boot_image = "dv/boot_image.hex";

	// ----------------------------------------------------------------------
	// Line fill sequencing
	// ----------------------------------------------------------------------
	typedef enum logic [1:0] {
		st_wait,    // Idle between lines.
		st_read,    // ROM address presented.
		st_capture  // ROM word written into the line.
	} fill_state_t;

endpackage

// ==== logic/mem_pkg.sv ====
package mem_pkg;

	// ----------------------------------------------------------------------
	// Word and line geometry
	// ----------------------------------------------------------------------
	localparam int word_w         = 32;
	localparam int words_per_line = 16;
	localparam int line_w         = word_w * words_per_line; // 512 bits per cache line.
	localparam int beat_w         = $clog2(words_per_line);
	localparam int word_off_w     = $clog2(word_w / 8);      // Byte offset inside a word.
	localparam int line_off_w     = $clog2(line_w / 8);      // Byte offset inside a line.
	localparam int line_addr_w    = 32 - line_off_w;         // Byte address bits 31 to 6.
	localparam int word_addr_w    = 32 - word_off_w;         // Byte address bits 31 to 2.

	// ----------------------------------------------------------------------
	// Vector types
	// ----------------------------------------------------------------------
	typedef logic [word_w-1:0]      word_t;      // One instruction.
	typedef logic [line_w-1:0]      line_t;      // One cache line, slot 0 in the low bits.
	typedef logic [line_addr_w-1:0] line_addr_t;
	typedef logic [word_addr_w-1:0] word_addr_t; // Global word position.
	typedef logic [beat_w-1:0]      beat_t;      // Word index within a line.

endpackage
